/* src/vlan_demux_pkg.sv */
// ==============================
// Shared widths and constants for the VLAN demultiplexer
// Tag word sits in bits 127:96 of the first beat, with lanes
// byte-swapped as on the wire. BUF_DEPTH must be a power of two.
// ==============================
`default_nettype none

package vlan_demux_pkg;

  // Stream widths
  localparam int DATA_W = 256;
  localparam int KEEP_W = DATA_W / 8;
  localparam int USER_W = 128;

  // Output ports
  localparam int NUM_PORTS = 8;
  localparam int PORT_W    = 3;

  // 802.1Q tag location and values
  localparam int TAG_LSB = 96;
  localparam int TAG_W   = 32;
  localparam int VID_W   = 12;
  localparam logic [15:0]      VLAN_TPID = 16'h0081;
  localparam logic [VID_W-1:0] VID_FIRST = 12'd1;

  // Beat buffer and decision queue
  localparam int BUF_DEPTH = 4;
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

  // Tag word seen as two halves or as the individual fields
  typedef union packed {
    struct packed {
      logic [15:0] tci;
      logic [15:0] tpid;
    } halves;
    struct packed {
      logic [7:0]  vid_lo;
      logic [2:0]  prio;
      logic        drop;
      logic [3:0]  vid_hi;
      logic [15:0] tpid;
    } fields;
  } vlan_tag_u;

endpackage

`default_nettype wire

/* src/vlan_tag_parser.sv */
// ==============================
// Decodes the tag of each packet's first beat and queues one
// routing decision per packet. Queue depth equals the beat
// buffer depth, so it cannot overflow.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module vlan_tag_parser import vlan_demux_pkg::*; (
  input  wire logic              axis_aclk,
  input  wire logic              axis_resetn,
  input  wire logic              beat_accept,
  input  wire logic [DATA_W-1:0] beat_tdata,
  input  wire logic              beat_tlast,
  input  wire logic              dec_pop,
  output logic                   dec_valid,
  output logic [PORT_W-1:0]      dec_port,
  output logic                   dec_fwd
);

  logic             sop;
  vlan_tag_u        tag;
  logic [VID_W-1:0] vid;
  logic [VID_W-1:0] vid_off;
  logic             tpid_ok;
  logic             vid_ok;
  logic             push;

  // Pointers carry one extra bit to tell full from empty
  logic [BUF_PTR_W:0] wr_ptr;
  logic [BUF_PTR_W:0] rd_ptr;
  logic [PORT_W-1:0]  q_port [BUF_DEPTH];
  logic               q_fwd  [BUF_DEPTH];

  assign tag     = beat_tdata[TAG_LSB +: TAG_W];
  assign vid     = {tag.fields.vid_hi, tag.fields.vid_lo};
  assign vid_off = vid - VID_FIRST;
  assign tpid_ok = (tag.halves.tpid == VLAN_TPID);
  // VID 0 wraps to a large offset and falls out of range
  assign vid_ok  = (vid_off < VID_W'(NUM_PORTS));
  assign push    = beat_accept & sop;

  // Next accepted beat starts a packet after tlast
  always_ff @(posedge axis_aclk) begin
    if (axis_resetn) begin
      sop    <= 1'b1;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (beat_accept)
        sop <= beat_tlast;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (dec_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      q_port[wr_ptr[BUF_PTR_W-1:0]] <= vid_off[PORT_W-1:0];
      q_fwd[wr_ptr[BUF_PTR_W-1:0]]  <= tpid_ok & vid_ok;
    end
  end

  assign dec_valid = (wr_ptr != rd_ptr);
  assign dec_port  = q_port[rd_ptr[BUF_PTR_W-1:0]];
  assign dec_fwd   = q_fwd[rd_ptr[BUF_PTR_W-1:0]];

endmodule

`default_nettype wire

/* src/beat_buffer.sv */
// ==============================
// Small FIFO of whole input beats
// in_tready is registered, so a full buffer is seen one edge
// late and the FIFO never takes more than BUF_DEPTH beats.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module beat_buffer import vlan_demux_pkg::*; (
  input  wire logic              axis_aclk,
  input  wire logic              axis_resetn,
  input  wire logic [DATA_W-1:0] in_tdata,
  input  wire logic [KEEP_W-1:0] in_tkeep,
  input  wire logic [USER_W-1:0] in_tuser,
  input  wire logic              in_tlast,
  input  wire logic              in_tvalid,
  input  wire logic              head_pop,
  output logic                   in_tready,
  output logic                   beat_accept,
  output logic                   head_valid,
  output logic [DATA_W-1:0]      head_tdata,
  output logic [KEEP_W-1:0]      head_tkeep,
  output logic [USER_W-1:0]      head_tuser,
  output logic                   head_tlast
);

  logic [DATA_W-1:0] mem_tdata [BUF_DEPTH];
  logic [KEEP_W-1:0] mem_tkeep [BUF_DEPTH];
  logic [USER_W-1:0] mem_tuser [BUF_DEPTH];
  logic              mem_tlast [BUF_DEPTH];

  logic [BUF_PTR_W-1:0] wr_ptr;
  logic [BUF_PTR_W-1:0] rd_ptr;
  logic [BUF_CNT_W-1:0] count;
  logic [BUF_CNT_W-1:0] count_next;

  assign beat_accept = in_tvalid & in_tready;
  assign count_next  = count + BUF_CNT_W'(beat_accept) - BUF_CNT_W'(head_pop);

  always_ff @(posedge axis_aclk) begin
    if (axis_resetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_tready <= 1'b0;
    end else begin
      if (beat_accept)
        wr_ptr <= wr_ptr + 1'b1;
      if (head_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count     <= count_next;
      // Ready for the next cycle only if a slot is left
      in_tready <= (count_next != BUF_CNT_W'(BUF_DEPTH));
    end
  end

  // Storage
  always_ff @(posedge axis_aclk) begin
    if (beat_accept) begin
      mem_tdata[wr_ptr] <= in_tdata;
      mem_tkeep[wr_ptr] <= in_tkeep;
      mem_tuser[wr_ptr] <= in_tuser;
      mem_tlast[wr_ptr] <= in_tlast;
    end
  end

  assign head_valid = (count != '0);
  assign head_tdata = mem_tdata[rd_ptr];
  assign head_tkeep = mem_tkeep[rd_ptr];
  assign head_tuser = mem_tuser[rd_ptr];
  assign head_tlast = mem_tlast[rd_ptr];

endmodule

`default_nettype wire

/* src/port_steer.sv */
// ==============================
// Pairs the head decision with head beats. Forwarded beats go
// through one output register shared by all ports; at most one
// out_tvalid bit is high. Discarded beats drain one per cycle.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module port_steer import vlan_demux_pkg::*; (
  input  wire logic                 axis_aclk,
  input  wire logic                 axis_resetn,
  input  wire logic                 head_valid,
  input  wire logic [DATA_W-1:0]    head_tdata,
  input  wire logic [KEEP_W-1:0]    head_tkeep,
  input  wire logic [USER_W-1:0]    head_tuser,
  input  wire logic                 head_tlast,
  input  wire logic                 dec_valid,
  input  wire logic [PORT_W-1:0]    dec_port,
  input  wire logic                 dec_fwd,
  input  wire logic [NUM_PORTS-1:0] out_tready,
  output logic                      head_pop,
  output logic                      dec_pop,
  output logic [DATA_W-1:0]         out_tdata,
  output logic [KEEP_W-1:0]         out_tkeep,
  output logic [USER_W-1:0]         out_tuser,
  output logic                      out_tlast,
  output logic [NUM_PORTS-1:0]      out_tvalid
);

  logic                 active;
  logic                 out_taken;
  logic                 out_free;
  logic                 load;
  logic                 discard;
  logic [NUM_PORTS-1:0] port_sel;

  // Need both a beat and its packet's decision
  assign active    = head_valid & dec_valid;

  // Output register can take a new beat when empty or draining now
  assign out_taken = |(out_tvalid & out_tready);
  assign out_free  = ~(|out_tvalid) | out_taken;

  assign load      = active & dec_fwd & out_free;
  assign discard   = active & ~dec_fwd;
  assign head_pop  = load | discard;
  // Last beat of the packet retires its decision
  assign dec_pop   = head_pop & head_tlast;

  assign port_sel  = NUM_PORTS'(1) << dec_port;

  always_ff @(posedge axis_aclk) begin
    if (axis_resetn) begin
      out_tvalid <= '0;
    end else if (load) begin
      out_tvalid <= port_sel;
    end else if (out_taken) begin
      out_tvalid <= '0;
    end
  end

  // Payload held until the selected port takes it
  always_ff @(posedge axis_aclk) begin
    if (load) begin
      out_tdata <= head_tdata;
      out_tkeep <= head_tkeep;
      out_tuser <= head_tuser;
      out_tlast <= head_tlast;
    end
  end

endmodule

`default_nettype wire

/* src/vlan_demux.sv */
// ==============================
// VLAN tag demultiplexer, one stream in and eight out
// Outputs share one data bus with a valid and ready per port.
// Packets with a bad TPID or VID outside 1..8 are dropped.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module vlan_demux import vlan_demux_pkg::*; (
  input  wire logic                 axis_aclk,
  input  wire logic                 axis_resetn,
  input  wire logic [DATA_W-1:0]    in_tdata,
  input  wire logic [KEEP_W-1:0]    in_tkeep,
  input  wire logic [USER_W-1:0]    in_tuser,
  input  wire logic                 in_tlast,
  input  wire logic                 in_tvalid,
  output logic                      in_tready,
  output logic [DATA_W-1:0]         out_tdata,
  output logic [KEEP_W-1:0]         out_tkeep,
  output logic [USER_W-1:0]         out_tuser,
  output logic                      out_tlast,
  output logic [NUM_PORTS-1:0]      out_tvalid,
  input  wire logic [NUM_PORTS-1:0] out_tready
);

  logic              beat_accept;
  logic              dec_valid;
  logic [PORT_W-1:0] dec_port;
  logic              dec_fwd;
  logic              dec_pop;
  logic              head_valid;
  logic [DATA_W-1:0] head_tdata;
  logic [KEEP_W-1:0] head_tkeep;
  logic [USER_W-1:0] head_tuser;
  logic              head_tlast;
  logic              head_pop;

  // Parser sees the input beat directly, qualified by beat_accept
  vlan_tag_parser parser_inst (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .beat_accept (beat_accept),
    .beat_tdata  (in_tdata),
    .beat_tlast  (in_tlast),
    .dec_pop     (dec_pop),
    .dec_valid   (dec_valid),
    .dec_port    (dec_port),
    .dec_fwd     (dec_fwd)
  );

  beat_buffer buffer_inst (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .in_tdata    (in_tdata),
    .in_tkeep    (in_tkeep),
    .in_tuser    (in_tuser),
    .in_tlast    (in_tlast),
    .in_tvalid   (in_tvalid),
    .head_pop    (head_pop),
    .in_tready   (in_tready),
    .beat_accept (beat_accept),
    .head_valid  (head_valid),
    .head_tdata  (head_tdata),
    .head_tkeep  (head_tkeep),
    .head_tuser  (head_tuser),
    .head_tlast  (head_tlast)
  );

  port_steer steer_inst (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .head_valid  (head_valid),
    .head_tdata  (head_tdata),
    .head_tkeep  (head_tkeep),
    .head_tuser  (head_tuser),
    .head_tlast  (head_tlast),
    .dec_valid   (dec_valid),
    .dec_port    (dec_port),
    .dec_fwd     (dec_fwd),
    .out_tready  (out_tready),
    .head_pop    (head_pop),
    .dec_pop     (dec_pop),
    .out_tdata   (out_tdata),
    .out_tkeep   (out_tkeep),
    .out_tuser   (out_tuser),
    .out_tlast   (out_tlast),
    .out_tvalid  (out_tvalid)
  );

endmodule

`default_nettype wire

/* verif/vlan_demux_model.svh */
// ==============================
// Testbench model, included inside the testbench module.
// Uses its lfsr state and counters. Tags are built from the
// wire lane order, with the VID split as info 3:0 over 15:8.
// ==============================
`ifndef VLAN_DEMUX_MODEL_SVH
`define VLAN_DEMUX_MODEL_SVH

localparam int BEAT_W = DATA_W + KEEP_W + USER_W + 1;

// Expected beats per port, packed as {tdata, tkeep, tuser, tlast}
logic [BEAT_W-1:0] exp_q [NUM_PORTS][$];

// Galois form, taps 32 31 29 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  int          i;
  v = '0;
  for (i = 0; i < n; i++) begin
    lfsr = lfsr_next(lfsr);
    v    = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

function automatic logic [15:0] wrong_tpid();
  logic [15:0] t;
  t = 16'(take_bits(16));
  return (t == VLAN_TPID) ? 16'h8100 : t;
endfunction

// Priority and drop bits are random, nothing routes on them
function automatic logic [31:0] make_tag(input logic [15:0] tpid, input logic [11:0] vid);
  logic [3:0] pcp_dei;
  pcp_dei = 4'(take_bits(4));
  return {vid[7:0], pcp_dei, vid[11:8], tpid};
endfunction

function automatic logic [BEAT_W-1:0] make_beat(input logic [31:0] tag, input bit first,
                                                input bit last);
  logic [DATA_W-1:0] data;
  logic [KEEP_W-1:0] keep;
  logic [USER_W-1:0] user;
  int                nbytes;
  int                w;
  for (w = 0; w < DATA_W / 32; w++)
    data[w*32 +: 32] = take_bits(32);
  for (w = 0; w < USER_W / 32; w++)
    user[w*32 +: 32] = take_bits(32);
  if (first)
    data[TAG_LSB +: 32] = tag;
  // Partial keep on the last beat only
  nbytes = int'(take_bits(5)) + 1;
  keep   = last ? ({KEEP_W{1'b1}} >> (KEEP_W - nbytes)) : {KEEP_W{1'b1}};
  return {data, keep, user, last};
endfunction

task automatic compare_beat(input string what, input logic [BEAT_W-1:0] exp,
                            input logic [BEAT_W-1:0] act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    $display("error @ %0t: %s beat mismatch, expected %h got %h", $time, what, exp, act);
  end
endtask

task automatic compare_port(input int port, input int pending);
  check_count++;
  if (pending == 0) begin
    error_count++;
    $display("error @ %0t: beat on port %0d with no beat expected", $time, port);
  end
endtask

task automatic compare_valid(input string what, input logic [NUM_PORTS-1:0] exp,
                             input logic [NUM_PORTS-1:0] act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    $display("error @ %0t: %s expected %b got %b", $time, what, exp, act);
  end
endtask

task automatic compare_flag(input string what, input logic exp, input logic act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    $display("error @ %0t: %s expected %b got %b", $time, what, exp, act);
  end
endtask

`endif

/* verif/vlan_demux_tb.sv */
// ==============================
// Testbench for the VLAN demultiplexer
// All random stimulus and out_tready come from one LFSR,
// stepped only in the stimulus process.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module vlan_demux_tb import vlan_demux_pkg::*; ();

  localparam int          CLK_PERIOD  = 100;
  localparam int          DRIVE_DLY   = 5;
  localparam logic [31:0] SEED        = 32'd68708;
  localparam int          NUM_FWD     = 40;
  localparam int          NUM_DROP    = 30;
  localparam int          NUM_RDY     = 60;
  localparam int          NUM_MIX     = 80;
  localparam int          TOTAL_PKTS  = NUM_FWD + NUM_DROP + NUM_RDY + NUM_MIX;
  localparam int          WATCHDOG_NS = TOTAL_PKTS * 4 * 20 * CLK_PERIOD;

  logic                 axis_aclk;
  logic                 axis_resetn;
  logic [DATA_W-1:0]    in_tdata;
  logic [KEEP_W-1:0]    in_tkeep;
  logic [USER_W-1:0]    in_tuser;
  logic                 in_tlast;
  logic                 in_tvalid;
  logic                 in_tready;
  logic [DATA_W-1:0]    out_tdata;
  logic [KEEP_W-1:0]    out_tkeep;
  logic [USER_W-1:0]    out_tuser;
  logic                 out_tlast;
  logic [NUM_PORTS-1:0] out_tvalid;
  logic [NUM_PORTS-1:0] out_tready;

  logic [31:0]          lfsr = SEED;
  int                   error_count = 0;
  int                   check_count = 0;
  bit                   rand_ready  = 1'b0;
  bit                   accepted;
  logic [NUM_PORTS-1:0] hold_vld;
  logic [NUM_PORTS-1:0] hold_rdy;

  `include "vlan_demux_model.svh"

  logic [BEAT_W-1:0]    hold_beat;

  vlan_demux vlan_demux_inst (.*);

  initial axis_aclk = 1'b0;
  always #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;

  // Handshake is sampled at the edge, inputs change just after it
  task automatic next_cycle();
    @(posedge axis_aclk);
    accepted = in_tvalid & in_tready;
    #DRIVE_DLY;
    // Each port ready about three cycles in four
    out_tready = rand_ready ? NUM_PORTS'(take_bits(NUM_PORTS) | take_bits(NUM_PORTS)) : '1;
  endtask

  task automatic send_packet(input logic [15:0] tpid, input logic [11:0] vid, input int len,
                             input bit gaps);
    logic [BEAT_W-1:0] beat;
    logic [31:0]       tag;
    bit                fwd;
    int                b;
    tag = make_tag(tpid, vid);
    fwd = (tpid == VLAN_TPID) && (vid >= VID_FIRST) && (vid < VID_FIRST + NUM_PORTS);
    for (b = 0; b < len; b++) begin
      beat = make_beat(tag, b == 0, b == len - 1);
      if (fwd)
        exp_q[vid - VID_FIRST].push_back(beat);
      if (gaps && take_bits(2) == 0) begin
        in_tvalid = 1'b0;
        repeat (int'(take_bits(2)) + 1) next_cycle();
      end
      {in_tdata, in_tkeep, in_tuser, in_tlast} = beat;
      in_tvalid = 1'b1;
      do next_cycle(); while (!accepted);
    end
  endtask

  // Idle input, all ports ready, until every expected queue is empty
  task automatic drain();
    int pending;
    int p;
    in_tvalid  = 1'b0;
    rand_ready = 1'b0;
    do begin
      next_cycle();
      pending = 0;
      for (p = 0; p < NUM_PORTS; p++)
        pending += exp_q[p].size();
    end while (pending != 0);
    repeat (2 * BUF_DEPTH + 4) next_cycle();
    compare_valid("out_tvalid when idle", '0, out_tvalid);
    compare_flag("in_tready when idle", 1'b1, in_tready);
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = error_count;
    repeat (4) begin
      next_cycle();
      compare_flag("in_tready during reset", 1'b0, in_tready);
      compare_valid("out_tvalid during reset", '0, out_tvalid);
    end
    axis_resetn = 1'b0;
    repeat (BUF_DEPTH) begin
      next_cycle();
      compare_valid("out_tvalid after reset", '0, out_tvalid);
    end
    $display("test reset_idle: %0d errors", error_count - errs_before);
  endtask

  // Kinds: 1 forward, 2 drop, 3 random ready, 4 mixed
  task automatic run_test(input string name, input int kind, input int npkts);
    int          errs_before;
    int          len;
    int          i;
    logic [15:0] tpid;
    logic [11:0] vid;
    errs_before = error_count;
    rand_ready  = (kind >= 3);
    for (i = 0; i < npkts; i++) begin
      tpid = VLAN_TPID;
      vid  = 12'(take_bits(3)) + 12'd1;
      len  = int'(take_bits(2)) + 1;
      if (kind == 1 && i < NUM_PORTS) begin
        // One single-beat packet per port
        vid = 12'(i + 1);
        len = 1;
      end else if (kind == 2 && i % 2 == 0) begin
        if (take_bits(1) == 1)
          tpid = wrong_tpid();
        else
          vid = (take_bits(2) == 0) ? 12'd0 : 12'(9 + take_bits(2) % 3);
      end else if (kind == 4) begin
        vid = 12'(take_bits(4) % 12);
        if (take_bits(2) == 0)
          tpid = wrong_tpid();
      end
      send_packet(tpid, vid, len, kind >= 3);
    end
    drain();
    $display("test %s: %0d packets, %0d errors", name, npkts, error_count - errs_before);
  endtask

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_mon
    always @(posedge axis_aclk) begin
      if (!axis_resetn && out_tvalid[p] && out_tready[p]) begin
        compare_port(p, exp_q[p].size());
        if (exp_q[p].size() != 0)
          compare_beat($sformatf("port %0d", p), exp_q[p].pop_front(),
                       {out_tdata, out_tkeep, out_tuser, out_tlast});
      end
    end
  end

  // Shared bus stays put while the selected port stalls
  always @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      compare_flag("out_tvalid at most one-hot", 1'b1,
                   (out_tvalid & (out_tvalid - 1'b1)) == '0);
      if (|(hold_vld & ~hold_rdy)) begin
        compare_valid("stalled out_tvalid", hold_vld, out_tvalid);
        compare_beat("stalled", hold_beat, {out_tdata, out_tkeep, out_tuser, out_tlast});
      end
    end
    hold_vld  <= axis_resetn ? '0 : out_tvalid;
    hold_rdy  <= out_tready;
    hold_beat <= {out_tdata, out_tkeep, out_tuser, out_tlast};
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    axis_resetn = 1'b1;
    in_tdata    = '0;
    in_tkeep    = '0;
    in_tuser    = '0;
    in_tlast    = 1'b0;
    in_tvalid   = 1'b0;
    out_tready  = '1;
    check_reset();
    run_test("forward_all_ready", 1, NUM_FWD);
    run_test("drop_bad_tags", 2, NUM_DROP);
    run_test("random_ready", 3, NUM_RDY);
    run_test("mixed_random", 4, NUM_MIX);
    $display("summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verif
src/vlan_demux_pkg.sv
src/vlan_tag_parser.sv
src/beat_buffer.sv
src/port_steer.sv
src/vlan_demux.sv
verif/vlan_demux_tb.sv

/* Bender.yml */
package:
  name: vlan_demux

sources:
  - src/vlan_demux_pkg.sv
  - src/vlan_tag_parser.sv
  - src/beat_buffer.sv
  - src/port_steer.sv
  - src/vlan_demux.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/vlan_demux_tb.sv
